// File: Bender.yml
package:
  name: decode_stage

sources:
  - decode_pkg.sv
  - alu_format_decoder.sv
  - mem_format_decoder.sv
  - branch_format_decoder.sv
  - decode_output_stage.sv
  - decode_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - decode_tb.sv

// File: alu_format_decoder.sv
// ALU format decoder
`timescale 1ns/100ps

module alu_format_decoder (
	input  decode_pkg::instruction_t   instruction,
	input  decode_pkg::register_t      pc,
	input  decode_pkg::thread_id_t     thread_id,
	output logic                       alu_hit,
	output decode_pkg::decoded_instr_t alu_instr
);

	decode_pkg::rr_body_t  rr_body;
	decode_pkg::ri_body_t  ri_body;
	decode_pkg::mvi_body_t mvi_body;
	logic [5 : 0]          alu_code;
	logic                  is_rr;
	logic                  is_ri;
	logic                  is_mvi;
	logic                  is_int_code;

	assign rr_body  = decode_pkg::rr_body_t'(instruction.body);
	assign ri_body  = decode_pkg::ri_body_t'(instruction.body);
	assign mvi_body = decode_pkg::mvi_body_t'(instruction.body);
	assign alu_code = instruction.opcode[5 : 0];

	assign is_rr   = instruction.opcode[7 : 6] == decode_pkg::rr_prefix;
	assign is_ri   = instruction.opcode[7 : 5] == decode_pkg::ri_prefix;
	assign is_mvi  = instruction.opcode[7 : 3] == decode_pkg::mvi_prefix;
	assign alu_hit = is_rr | is_ri | is_mvi;

	// Integer set: plain integer ops up to move, sign extensions and mask creation
	assign is_int_code = alu_code <= decode_pkg::op_move
		|| (alu_code >= decode_pkg::op_sext8 && alu_code <= decode_pkg::op_sext32)
		|| alu_code == decode_pkg::op_crt_mask;

	always_comb begin
		alu_instr           = '0;
		alu_instr.pc        = pc;
		alu_instr.thread_id = thread_id;

		if (is_rr) begin
			alu_instr.op_code                  = {2'b00, alu_code};
			alu_instr.source0                  = rr_body.source0;
			alu_instr.source1                  = rr_body.source1;
			alu_instr.destination              = rr_body.destination;
			alu_instr.has_source0              = 1'b1;
			alu_instr.has_source1              = 1'b1;
			alu_instr.has_destination          = 1'b1;
			alu_instr.is_source0_vectorial     = rr_body.register_selection[1];
			alu_instr.is_source1_vectorial     = rr_body.register_selection[0];
			alu_instr.is_destination_vectorial = rr_body.register_selection[2];
			alu_instr.mask_enable              = |rr_body.register_selection;

			if (is_int_code) begin
				alu_instr.pipe_sel = decode_pkg::PIPE_INT;
				alu_instr.is_int   = 1'b1;
			end else if (alu_code == decode_pkg::op_crp_v_32) begin
				alu_instr.pipe_sel = decode_pkg::PIPE_CRP;
			end else begin
				alu_instr.pipe_sel = decode_pkg::PIPE_FP;
				alu_instr.is_fp    = 1'b1;
			end

			// Writing the program counter turns the operation into a jump
			alu_instr.is_branch = rr_body.destination == decode_pkg::pc_reg;
		end else if (is_ri) begin
			alu_instr.op_code                  = {3'b000, instruction.opcode[4 : 0]};
			alu_instr.source0                  = ri_body.source0;
			alu_instr.destination              = ri_body.destination;
			alu_instr.has_source0              = 1'b1;
			alu_instr.has_destination          = 1'b1;
			alu_instr.is_source0_vectorial     = ri_body.register_selection[0];
			alu_instr.is_destination_vectorial = ri_body.register_selection[1];
			alu_instr.mask_enable              = |ri_body.register_selection;
			alu_instr.immediate                = {{23{ri_body.immediate[8]}}, ri_body.immediate};
			alu_instr.is_source1_immediate     = 1'b1;
			alu_instr.pipe_sel                 = decode_pkg::PIPE_INT;
			alu_instr.is_int                   = 1'b1;
		end else if (is_mvi) begin
			alu_instr.op_code                  = {5'b00000, instruction.opcode[2 : 0]};
			alu_instr.destination              = mvi_body.destination;
			alu_instr.has_destination          = 1'b1;
			// A vector destination is written under the lane mask
			alu_instr.is_destination_vectorial = mvi_body.register_selection;
			alu_instr.mask_enable              = mvi_body.register_selection;
			alu_instr.immediate                = {{16{mvi_body.immediate[15]}}, mvi_body.immediate};
			alu_instr.is_source1_immediate     = 1'b1;
			alu_instr.pipe_sel                 = decode_pkg::PIPE_INT;
			alu_instr.is_movei                 = 1'b1;
		end
	end

	// The integer and floating-point pipes never share one instruction
	a_int_fp_exclusive: assert final (!(alu_instr.is_int && alu_instr.is_fp))
		else $error("ALU decoder marked an instruction both integer and floating point");

endmodule

// File: branch_format_decoder.sv
// Jump format decoder
`timescale 1ns/100ps

module branch_format_decoder (
	input  decode_pkg::instruction_t   instruction,
	input  decode_pkg::register_t      pc,
	input  decode_pkg::thread_id_t     thread_id,
	output logic                       branch_hit,
	output decode_pkg::decoded_instr_t branch_instr
);

	decode_pkg::jump_body_t jump_body;
	logic [2 : 0]           jump_code;
	logic                   is_jba;
	logic                   is_jra;
	logic                   is_call;
	logic                   is_return;

	assign jump_body  = decode_pkg::jump_body_t'(instruction.body);
	assign jump_code  = instruction.opcode[2 : 0];
	assign is_jba     = instruction.opcode[7 : 3] == decode_pkg::jba_prefix;
	assign is_jra     = instruction.opcode[7 : 3] == decode_pkg::jra_prefix;
	assign branch_hit = is_jba | is_jra;
	assign is_call    = jump_code == decode_pkg::jmpsr;
	assign is_return  = jump_code == decode_pkg::jret;

	always_comb begin
		branch_instr           = '0;
		branch_instr.pc        = pc;
		branch_instr.thread_id = thread_id;

		if (branch_hit) begin
			branch_instr.op_code   = {5'b00000, jump_code};
			branch_instr.immediate = {{14{jump_body.immediate[17]}}, jump_body.immediate};
			branch_instr.pipe_sel  = decode_pkg::PIPE_BRANCH;
			branch_instr.is_branch = 1'b1;
			branch_instr.branch_type    = is_jba ? decode_pkg::JBA : decode_pkg::JRA;
			branch_instr.is_conditional = is_jba & jump_code[2];

			// Relative jumps always add the immediate to the program counter
			branch_instr.is_source1_immediate = is_jra;

			if (is_call) begin
				// The link value is computed on the integer side from the pc
				branch_instr.destination     = decode_pkg::ra_reg;
				branch_instr.has_destination = 1'b1;
				branch_instr.is_int          = 1'b1;
				branch_instr.has_source0     = 1'b1;
				if (is_jba) begin
					branch_instr.source0     = jump_body.dest;
					branch_instr.source1     = decode_pkg::pc_reg;
					branch_instr.has_source1 = 1'b1;
				end else begin
					branch_instr.source0 = decode_pkg::pc_reg;
				end
			end else if (is_return) begin
				branch_instr.source0     = decode_pkg::ra_reg;
				branch_instr.has_source0 = 1'b1;
			end else if (is_jba) begin
				// Source0 holds the condition or the base, source1 the target register
				branch_instr.source0              = jump_body.dest;
				branch_instr.source1              = jump_body.dest;
				branch_instr.has_source0          = 1'b1;
				branch_instr.has_source1          = 1'b1;
				branch_instr.is_source1_immediate = 1'b1;
			end
		end
	end

	// A return only reads the link register
	a_return_no_dest: assert final (!(branch_hit && is_return && branch_instr.has_destination))
		else $error("Jump decoder gave a return a destination register");

endmodule

// File: decode_output_stage.sv
// Decode output register
`timescale 1ns/100ps

module decode_output_stage (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 enable,
	input  logic                                 if_valid,
	input  decode_pkg::thread_id_t               if_thread_id,
	input  logic [decode_pkg::thread_numb - 1 : 0] rollback_valid,
	input  logic                                 alu_hit,
	input  logic                                 mem_hit,
	input  logic                                 branch_hit,
	input  decode_pkg::decoded_instr_t           alu_instr,
	input  decode_pkg::decoded_instr_t           mem_instr,
	input  decode_pkg::decoded_instr_t           branch_instr,
	output logic                                 dec_valid,
	output decode_pkg::decoded_instr_t           dec_instr
);

	decode_pkg::decoded_instr_t selected_instr;
	logic                       any_hit;
	logic                       is_rollback;

	assign any_hit     = alu_hit | mem_hit | branch_hit;
	assign is_rollback = rollback_valid[if_thread_id];

	// An unknown opcode leaves the record all zeros
	always_comb begin
		if (alu_hit)
			selected_instr = alu_instr;
		else if (mem_hit)
			selected_instr = mem_instr;
		else if (branch_hit)
			selected_instr = branch_instr;
		else
			selected_instr = '0;
	end

	// Low enable holds both outputs while the fetch side keeps its inputs
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			dec_valid <= 1'b0;
			dec_instr <= '0;
		end else if (enable) begin
			dec_valid <= if_valid & ~is_rollback & any_hit;
			dec_instr <= selected_instr;
		end
	end

	// The decoders test disjoint opcode prefixes
	a_hits_onehot: assert property (
		@(posedge clk) disable iff (reset) $onehot0({alu_hit, mem_hit, branch_hit})
	) else $error("More than one decoder claimed the instruction");

	// After reset, valid stays low across every stalled edge until one accepts
	a_no_valid_before_accept: assert property (
		@(posedge clk) (reset || !dec_valid) && !enable |=> !dec_valid
	) else $error("dec_valid rose without an accepting edge");

endmodule

// File: decode_pkg.sv
// Decode stage definitions
package decode_pkg;

	localparam int thread_numb    = 8;
	localparam int register_width = 32;
	localparam int reg_addr_width = 6;
	localparam int op_code_width  = 8;

	typedef logic [$clog2(thread_numb) - 1 : 0] thread_id_t;
	typedef logic [register_width - 1 : 0]      register_t;
	typedef logic [reg_addr_width - 1 : 0]      reg_addr_t;

	// Architectural registers with a fixed role
	localparam reg_addr_t pc_reg = 6'd63;
	localparam reg_addr_t ra_reg = 6'd62;

	typedef struct packed {
		logic [op_code_width - 1 : 0] opcode;
		logic [23 : 0]                body;
	} instruction_t;

	// All bodies are 24 bits; spare bits sit at the top and are ignored
	typedef struct packed {
		logic [2 : 0] reserved;
		logic [2 : 0] register_selection;
		reg_addr_t    destination;
		reg_addr_t    source0;
		reg_addr_t    source1;
	} rr_body_t;

	typedef struct packed {
		logic         reserved;
		logic [1 : 0] register_selection;
		reg_addr_t    destination;
		reg_addr_t    source0;
		logic [8 : 0] immediate;
	} ri_body_t;

	typedef struct packed {
		logic          reserved;
		logic          register_selection;
		reg_addr_t     destination;
		logic [15 : 0] immediate;
	} mvi_body_t;

	typedef struct packed {
		logic [1 : 0] reserved;
		logic         shared;
		reg_addr_t    base_register;
		reg_addr_t    src_dest_register;
		logic [8 : 0] offset;
	} mem_body_t;

	typedef struct packed {
		reg_addr_t     dest;
		logic [17 : 0] immediate;
	} jump_body_t;

	// Opcode prefixes, compared against the top bits of the opcode
	localparam logic [1 : 0] rr_prefix  = 2'b00;
	localparam logic [1 : 0] mem_prefix = 2'b10;
	localparam logic [2 : 0] ri_prefix  = 3'b010;
	localparam logic [4 : 0] mvi_prefix = 5'b01100;
	localparam logic [4 : 0] jba_prefix = 5'b01110;
	localparam logic [4 : 0] jra_prefix = 5'b01111;

	// ALU operation codes that steer the pipe choice
	localparam logic [5 : 0] op_move     = 6'd32;
	localparam logic [5 : 0] op_sext8    = 6'd41;
	localparam logic [5 : 0] op_sext32   = 6'd43;
	localparam logic [5 : 0] op_crt_mask = 6'd48;
	localparam logic [5 : 0] op_crp_v_32 = 6'd49;

	// Memory operation codes, bit 5 marks a store
	localparam logic [5 : 0] load_v_8    = 6'd7;
	localparam logic [5 : 0] load_v_32_u = 6'd13;
	localparam logic [5 : 0] store_v_8   = 6'd36;
	localparam logic [5 : 0] store_v_64  = 6'd39;

	// Jump codes, bit 2 marks a conditional jump
	localparam logic [2 : 0] jmpsr = 3'd1;
	localparam logic [2 : 0] jret  = 3'd2;

	typedef enum logic [2 : 0] {
		PIPE_INT,
		PIPE_FP,
		PIPE_CRP,
		PIPE_MEM,
		PIPE_SPM,
		PIPE_BRANCH
	} pipe_sel_t;

	typedef enum logic {
		JBA,
		JRA
	} branch_type_t;

	typedef struct packed {
		register_t                    pc;
		thread_id_t                   thread_id;
		logic [op_code_width - 1 : 0] op_code;
		reg_addr_t                    source0;
		reg_addr_t                    source1;
		reg_addr_t                    destination;
		logic                         has_source0;
		logic                         has_source1;
		logic                         has_destination;
		logic                         is_source0_vectorial;
		logic                         is_source1_vectorial;
		logic                         is_destination_vectorial;
		register_t                    immediate;
		logic                         is_source1_immediate;
		logic                         mask_enable;
		pipe_sel_t                    pipe_sel;
		logic                         is_memory_access;
		logic                         is_int;
		logic                         is_fp;
		logic                         is_load;
		logic                         is_movei;
		logic                         is_branch;
		logic                         is_conditional;
		branch_type_t                 branch_type;
	} decoded_instr_t;

endpackage

// File: decode_checks.svh
// Decode stage compare tasks
`ifndef DECODE_CHECKS_SVH
`define DECODE_CHECKS_SVH

	int valid_errors = 0;
	int pipe_errors  = 0;
	int instr_errors = 0;

	task automatic check_valid(input logic got, input logic exp);
		if (got !== exp) begin
			valid_errors++;
			$display("Fail dec_valid: got %h, expected %h at %0t", got, exp, $time);
		end
	endtask

	task automatic check_pipe(input decode_pkg::pipe_sel_t got, input decode_pkg::pipe_sel_t exp);
		if (got !== exp) begin
			pipe_errors++;
			$display("Fail dec_instr.pipe_sel: got %h, expected %h at %0t", got, exp, $time);
		end
	endtask

	// One record field, zero-extended so every width shares this task
	task automatic check_field(input string name, input logic [31 : 0] got,
		input logic [31 : 0] exp);
		if (got !== exp) begin
			instr_errors++;
			$display("Fail dec_instr.%s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// The pipe choice has its own compare task
	task automatic check_instr(input decode_pkg::decoded_instr_t got,
		input decode_pkg::decoded_instr_t exp);
		check_field("pc", got.pc, exp.pc);
		check_field("thread_id", got.thread_id, exp.thread_id);
		check_field("op_code", got.op_code, exp.op_code);
		check_field("source0", got.source0, exp.source0);
		check_field("source1", got.source1, exp.source1);
		check_field("destination", got.destination, exp.destination);
		check_field("has_source0", got.has_source0, exp.has_source0);
		check_field("has_source1", got.has_source1, exp.has_source1);
		check_field("has_destination", got.has_destination, exp.has_destination);
		check_field("is_source0_vectorial", got.is_source0_vectorial, exp.is_source0_vectorial);
		check_field("is_source1_vectorial", got.is_source1_vectorial, exp.is_source1_vectorial);
		check_field("is_destination_vectorial", got.is_destination_vectorial,
			exp.is_destination_vectorial);
		check_field("immediate", got.immediate, exp.immediate);
		check_field("is_source1_immediate", got.is_source1_immediate, exp.is_source1_immediate);
		check_field("mask_enable", got.mask_enable, exp.mask_enable);
		check_field("is_memory_access", got.is_memory_access, exp.is_memory_access);
		check_field("is_int", got.is_int, exp.is_int);
		check_field("is_fp", got.is_fp, exp.is_fp);
		check_field("is_load", got.is_load, exp.is_load);
		check_field("is_movei", got.is_movei, exp.is_movei);
		check_field("is_branch", got.is_branch, exp.is_branch);
		check_field("is_conditional", got.is_conditional, exp.is_conditional);
		check_field("branch_type", got.branch_type, exp.branch_type);
	endtask

`endif

// File: decode_tb.sv
// Decode stage testbench
`timescale 1ns/100ps

module decode_tb;

	localparam int max_cycles = 400;

	logic                                   clk;
	logic                                   reset;
	logic                                   enable;
	logic                                   if_valid;
	decode_pkg::thread_id_t                 if_thread_id;
	decode_pkg::register_t                  if_pc;
	decode_pkg::instruction_t               if_instruction;
	logic [decode_pkg::thread_numb - 1 : 0] rollback_valid;
	logic                                   dec_valid;
	decode_pkg::decoded_instr_t             dec_instr;

	decode_pkg::register_t      ctx_pc;
	decode_pkg::thread_id_t     ctx_tid;
	int                         rollback_offset;
	int                         cycle_count = 0;
	logic                       fetch_valid;
	logic                       held_valid;
	decode_pkg::decoded_instr_t held_exp;

	`include "decode_checks.svh"

	decode_top dut_i (
		.clk            (clk),
		.reset          (reset),
		.enable         (enable),
		.if_valid       (if_valid),
		.if_thread_id   (if_thread_id),
		.if_pc          (if_pc),
		.if_instruction (if_instruction),
		.rollback_valid (rollback_valid),
		.dec_valid      (dec_valid),
		.dec_instr      (dec_instr)
	);

	always #20 clk = ~clk;

	// Limit sits well beyond the length of the directed tests
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("Timeout: the tests did not finish within %0d cycles", max_cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	function automatic decode_pkg::reg_addr_t rand_reg();
		logic [31 : 0] word;
		word = $urandom_range(61, 0);
		return word[5 : 0];
	endfunction

	task automatic new_context();
		logic [31 : 0] word;
		ctx_pc  = $urandom();
		word    = $urandom_range(decode_pkg::thread_numb - 1, 0);
		ctx_tid = word[2 : 0];
	endtask

	function automatic decode_pkg::decoded_instr_t base_record();
		decode_pkg::decoded_instr_t rec;
		rec           = '0;
		rec.pc        = ctx_pc;
		rec.thread_id = ctx_tid;
		return rec;
	endfunction

	task automatic drive(input decode_pkg::instruction_t ins, input logic en);
		enable         = en;
		if_valid       = fetch_valid;
		if_pc          = ctx_pc;
		if_thread_id   = ctx_tid;
		if_instruction = ins;
		rollback_valid = '0;
		if (rollback_offset >= 0)
			rollback_valid[ctx_tid + rollback_offset[2 : 0]] = 1'b1;
	endtask

	task automatic step();
		@(posedge clk);
		#5;
	endtask

	task automatic expect_out(input logic valid, input decode_pkg::decoded_instr_t exp);
		check_valid(dec_valid, valid);
		check_pipe(dec_instr.pipe_sel, exp.pipe_sel);
		check_instr(dec_instr, exp);
	endtask

	// A record shows up on the edge after it is driven and not before
	task automatic apply(input decode_pkg::instruction_t ins, input logic en, input logic hit,
		input decode_pkg::decoded_instr_t exp);
		drive(ins, en);
		#1;
		expect_out(held_valid, held_exp);
		if (en) begin
			held_valid = fetch_valid & hit & ~rollback_valid[ctx_tid];
			held_exp   = exp;
		end
		step();
		expect_out(held_valid, held_exp);
	endtask

	function automatic decode_pkg::pipe_sel_t rr_pipe(input logic [5 : 0] code);
		if (code <= decode_pkg::op_move || code == decode_pkg::op_crt_mask
			|| (code >= decode_pkg::op_sext8 && code <= decode_pkg::op_sext32))
			return decode_pkg::PIPE_INT;
		else if (code == decode_pkg::op_crp_v_32)
			return decode_pkg::PIPE_CRP;
		return decode_pkg::PIPE_FP;
	endfunction

	task automatic test_rr(input logic [5 : 0] code, input logic [2 : 0] sel,
		input decode_pkg::reg_addr_t dest);
		decode_pkg::instruction_t   ins;
		decode_pkg::decoded_instr_t exp;
		decode_pkg::reg_addr_t      src0;
		decode_pkg::reg_addr_t      src1;
		new_context();
		src0 = rand_reg();
		src1 = rand_reg();
		ins  = {decode_pkg::rr_prefix, code, 3'b000, sel, dest, src0, src1};
		exp  = base_record();
		exp.op_code                  = {2'b00, code};
		exp.source0                  = src0;
		exp.source1                  = src1;
		exp.destination              = dest;
		exp.has_source0              = 1'b1;
		exp.has_source1              = 1'b1;
		exp.has_destination          = 1'b1;
		exp.is_source0_vectorial     = sel[1];
		exp.is_source1_vectorial     = sel[0];
		exp.is_destination_vectorial = sel[2];
		exp.mask_enable              = sel != 3'b000;
		exp.pipe_sel                 = rr_pipe(code);
		exp.is_int                   = exp.pipe_sel == decode_pkg::PIPE_INT;
		exp.is_fp                    = exp.pipe_sel == decode_pkg::PIPE_FP;
		exp.is_branch                = dest == decode_pkg::pc_reg;
		apply(ins, 1'b1, 1'b1, exp);
	endtask

	task automatic test_ri(input logic [4 : 0] code, input logic [1 : 0] sel,
		input logic [8 : 0] imm);
		decode_pkg::instruction_t   ins;
		decode_pkg::decoded_instr_t exp;
		decode_pkg::reg_addr_t      src0;
		decode_pkg::reg_addr_t      dest;
		new_context();
		src0 = rand_reg();
		dest = rand_reg();
		ins  = {decode_pkg::ri_prefix, code, 1'b0, sel, dest, src0, imm};
		exp  = base_record();
		exp.op_code                  = {3'b000, code};
		exp.source0                  = src0;
		exp.destination              = dest;
		exp.has_source0              = 1'b1;
		exp.has_destination          = 1'b1;
		exp.is_source0_vectorial     = sel[0];
		exp.is_destination_vectorial = sel[1];
		exp.mask_enable              = sel != 2'b00;
		exp.immediate                = {{23{imm[8]}}, imm};
		exp.is_source1_immediate     = 1'b1;
		exp.pipe_sel                 = decode_pkg::PIPE_INT;
		exp.is_int                   = 1'b1;
		apply(ins, 1'b1, 1'b1, exp);
	endtask

	task automatic test_mvi(input logic [2 : 0] code, input logic sel, input logic [15 : 0] imm);
		decode_pkg::instruction_t   ins;
		decode_pkg::decoded_instr_t exp;
		decode_pkg::reg_addr_t      dest;
		new_context();
		dest = rand_reg();
		ins  = {decode_pkg::mvi_prefix, code, 1'b0, sel, dest, imm};
		exp  = base_record();
		exp.op_code                  = {5'b00000, code};
		exp.destination              = dest;
		exp.has_destination          = 1'b1;
		exp.is_destination_vectorial = sel;
		exp.mask_enable              = sel;
		exp.immediate                = {{16{imm[15]}}, imm};
		exp.is_source1_immediate     = 1'b1;
		exp.pipe_sel                 = decode_pkg::PIPE_INT;
		exp.is_movei                 = 1'b1;
		apply(ins, 1'b1, 1'b1, exp);
	endtask

	task automatic test_mem(input logic [5 : 0] code, input logic shared,
		input logic [8 : 0] offset);
		decode_pkg::instruction_t   ins;
		decode_pkg::decoded_instr_t exp;
		decode_pkg::reg_addr_t      base;
		decode_pkg::reg_addr_t      data;
		logic                       vector;
		new_context();
		base   = rand_reg();
		data   = rand_reg();
		vector = (code >= decode_pkg::load_v_8 && code <= decode_pkg::load_v_32_u)
			|| (code >= decode_pkg::store_v_8 && code <= decode_pkg::store_v_64);
		ins = {decode_pkg::mem_prefix, code, 2'b00, shared, base, data, offset};
		exp = base_record();
		exp.op_code                  = {2'b00, code};
		exp.source0                  = base;
		exp.source1                  = data;
		exp.destination              = data;
		exp.has_source0              = 1'b1;
		exp.has_source1              = 1'b1;
		exp.has_destination          = !code[5];
		exp.is_load                  = !code[5];
		exp.is_source1_vectorial     = vector;
		exp.is_destination_vectorial = vector;
		exp.mask_enable              = vector;
		exp.immediate                = {{23{offset[8]}}, offset};
		exp.is_memory_access         = 1'b1;
		exp.pipe_sel = shared ? decode_pkg::PIPE_SPM : decode_pkg::PIPE_MEM;
		apply(ins, 1'b1, 1'b1, exp);
	endtask

	task automatic test_jump(input logic is_jra, input logic [2 : 0] code);
		decode_pkg::instruction_t   ins;
		decode_pkg::decoded_instr_t exp;
		decode_pkg::reg_addr_t      dest;
		logic [31 : 0]              word;
		new_context();
		dest = rand_reg();
		word = $urandom();
		ins  = {is_jra ? decode_pkg::jra_prefix : decode_pkg::jba_prefix, code, dest, word[17 : 0]};
		exp  = base_record();
		exp.op_code              = {5'b00000, code};
		exp.immediate            = {{14{word[17]}}, word[17 : 0]};
		exp.pipe_sel             = decode_pkg::PIPE_BRANCH;
		exp.is_branch            = 1'b1;
		exp.branch_type          = is_jra ? decode_pkg::JRA : decode_pkg::JBA;
		exp.is_conditional       = !is_jra && code[2];
		exp.is_source1_immediate = is_jra;
		if (code == decode_pkg::jmpsr) begin
			// Call writes the link register from the program counter
			exp.destination     = decode_pkg::ra_reg;
			exp.has_destination = 1'b1;
			exp.is_int          = 1'b1;
			exp.has_source0     = 1'b1;
			exp.source0         = is_jra ? decode_pkg::pc_reg : dest;
			exp.source1         = is_jra ? 6'd0 : decode_pkg::pc_reg;
			exp.has_source1     = !is_jra;
		end else if (code == decode_pkg::jret) begin
			exp.source0     = decode_pkg::ra_reg;
			exp.has_source0 = 1'b1;
		end else if (!is_jra) begin
			exp.source0              = dest;
			exp.source1              = dest;
			exp.has_source0          = 1'b1;
			exp.has_source1          = 1'b1;
			exp.is_source1_immediate = 1'b1;
		end
		apply(ins, 1'b1, 1'b1, exp);
	endtask

	task automatic test_unknown(input logic [7 : 0] opcode);
		logic [31 : 0] word;
		new_context();
		word = $urandom();
		apply({opcode, word[23 : 0]}, 1'b1, 1'b0, '0);
	endtask

	// A bubble from the fetch side still decodes but is not marked valid
	task automatic test_bubble();
		fetch_valid = 1'b0;
		test_mem(6'd3, 1'b0, 9'h012);
		fetch_valid = 1'b1;
	endtask

	// Offset zero rolls back the incoming thread, any other offset a different one
	task automatic test_rollback(input logic own_thread);
		rollback_offset = own_thread ? 0 : 3;
		test_rr(6'd10, 3'b000, rand_reg());
		rollback_offset = -1;
	endtask

	task automatic test_stall();
		logic [31 : 0] word;
		new_context();
		word = $urandom();
		apply(word, 1'b0, 1'b0, '0);
		word = $urandom();
		apply(word, 1'b0, 1'b0, '0);
	endtask

	initial begin
		void'($urandom(32'h32fe6989));
		clk             = 1'b0;
		reset           = 1'b1;
		enable          = 1'b0;
		if_valid        = 1'b0;
		if_thread_id    = '0;
		if_pc           = '0;
		if_instruction  = '0;
		rollback_valid  = '0;
		rollback_offset = -1;
		fetch_valid     = 1'b1;
		held_valid      = 1'b0;
		held_exp        = '0;
		repeat (4) @(posedge clk);
		#5;
		reset = 1'b0;
		expect_out(1'b0, '0);

		test_rr(6'd5, 3'b000, rand_reg());
		test_rr(decode_pkg::op_sext8 + 6'd1, 3'b101, rand_reg());
		test_rr(decode_pkg::op_crt_mask, 3'b010, rand_reg());
		test_rr(decode_pkg::op_crp_v_32, 3'b001, rand_reg());
		test_rr(6'd36, 3'b100, rand_reg());
		test_rr(6'd45, 3'b111, rand_reg());
		test_rr(6'd3, 3'b000, decode_pkg::pc_reg);
		test_ri(5'd3, 2'b10, 9'h1f0);
		test_ri(5'd17, 2'b01, 9'h07f);
		test_mvi(3'd0, 1'b1, 16'h8001);
		test_mvi(3'd6, 1'b0, 16'h1234);
		test_mem(6'd2, 1'b0, 9'h100);
		test_mem(decode_pkg::load_v_32_u, 1'b1, 9'h00f);
		test_mem(6'd33, 1'b1, 9'h1ff);
		test_mem(decode_pkg::store_v_8, 1'b0, 9'h044);
		test_jump(1'b0, decode_pkg::jmpsr);
		test_jump(1'b1, decode_pkg::jmpsr);
		test_jump(1'b0, decode_pkg::jret);
		test_jump(1'b1, decode_pkg::jret);
		test_jump(1'b0, 3'd5);
		test_jump(1'b1, 3'd4);
		test_unknown(8'h68);
		test_unknown(8'hc5);
		test_bubble();
		test_rollback(1'b1);
		test_rollback(1'b0);
		test_stall();
		test_mem(6'd1, 1'b0, 9'h0a5);

		$display("Errors: dec_valid %0d, pipe_sel %0d, record fields %0d",
			valid_errors, pipe_errors, instr_errors);
		if (valid_errors + pipe_errors + instr_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: decode_top.sv
// Instruction decode stage
`timescale 1ns/100ps

module decode_top (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 enable,
	input  logic                                 if_valid,
	input  decode_pkg::thread_id_t               if_thread_id,
	input  decode_pkg::register_t                if_pc,
	input  decode_pkg::instruction_t             if_instruction,
	input  logic [decode_pkg::thread_numb - 1 : 0] rollback_valid,
	output logic                                 dec_valid,
	output decode_pkg::decoded_instr_t           dec_instr
);

	logic                       alu_hit;
	logic                       mem_hit;
	logic                       branch_hit;
	decode_pkg::decoded_instr_t alu_instr;
	decode_pkg::decoded_instr_t mem_instr;
	decode_pkg::decoded_instr_t branch_instr;

	alu_format_decoder alu_dec_i (
		.instruction (if_instruction),
		.pc          (if_pc),
		.thread_id   (if_thread_id),
		.alu_hit     (alu_hit),
		.alu_instr   (alu_instr)
	);

	mem_format_decoder mem_dec_i (
		.instruction (if_instruction),
		.pc          (if_pc),
		.thread_id   (if_thread_id),
		.mem_hit     (mem_hit),
		.mem_instr   (mem_instr)
	);

	branch_format_decoder branch_dec_i (
		.instruction  (if_instruction),
		.pc           (if_pc),
		.thread_id    (if_thread_id),
		.branch_hit   (branch_hit),
		.branch_instr (branch_instr)
	);

	decode_output_stage output_stage_i (
		.clk            (clk),
		.reset          (reset),
		.enable         (enable),
		.if_valid       (if_valid),
		.if_thread_id   (if_thread_id),
		.rollback_valid (rollback_valid),
		.alu_hit        (alu_hit),
		.mem_hit        (mem_hit),
		.branch_hit     (branch_hit),
		.alu_instr      (alu_instr),
		.mem_instr      (mem_instr),
		.branch_instr   (branch_instr),
		.dec_valid      (dec_valid),
		.dec_instr      (dec_instr)
	);

endmodule

// File: mem_format_decoder.sv
// Memory format decoder
`timescale 1ns/100ps

module mem_format_decoder (
	input  decode_pkg::instruction_t   instruction,
	input  decode_pkg::register_t      pc,
	input  decode_pkg::thread_id_t     thread_id,
	output logic                       mem_hit,
	output decode_pkg::decoded_instr_t mem_instr
);

	decode_pkg::mem_body_t mem_body;
	logic [5 : 0]          mem_code;
	logic                  is_store;
	logic                  is_vector;

	assign mem_body = decode_pkg::mem_body_t'(instruction.body);
	assign mem_code = instruction.opcode[5 : 0];
	assign mem_hit  = instruction.opcode[7 : 6] == decode_pkg::mem_prefix;
	assign is_store = mem_code[5];

	// Vector loads and stores each occupy a contiguous code range
	assign is_vector =
		(mem_code >= decode_pkg::load_v_8 && mem_code <= decode_pkg::load_v_32_u)
		|| (mem_code >= decode_pkg::store_v_8 && mem_code <= decode_pkg::store_v_64);

	always_comb begin
		mem_instr           = '0;
		mem_instr.pc        = pc;
		mem_instr.thread_id = thread_id;

		if (mem_hit) begin
			mem_instr.op_code     = {2'b00, mem_code};
			mem_instr.source0     = mem_body.base_register;
			mem_instr.source1     = mem_body.src_dest_register;
			mem_instr.destination = mem_body.src_dest_register;

			// A store reads its data through source1 and writes no register
			mem_instr.has_source0     = 1'b1;
			mem_instr.has_source1     = 1'b1;
			mem_instr.has_destination = !is_store;
			mem_instr.is_load         = !is_store;

			mem_instr.is_source1_vectorial     = is_vector;
			mem_instr.is_destination_vectorial = is_vector;
			mem_instr.mask_enable              = is_vector;

			// Source1 carries store data, so the offset travels only in the immediate
			mem_instr.immediate            = {{23{mem_body.offset[8]}}, mem_body.offset};
			mem_instr.is_source1_immediate = 1'b0;
			mem_instr.is_memory_access     = 1'b1;

			if (mem_body.shared)
				mem_instr.pipe_sel = decode_pkg::PIPE_SPM;
			else
				mem_instr.pipe_sel = decode_pkg::PIPE_MEM;
		end
	end

	a_load_has_dest: assert final (!(mem_hit && mem_instr.is_load && !mem_instr.has_destination))
		else $error("Memory decoder produced a load without a destination");

endmodule

// File: verilog.f
+incdir+.
decode_pkg.sv
alu_format_decoder.sv
mem_format_decoder.sv
branch_format_decoder.sv
decode_output_stage.sv
decode_top.sv
decode_tb.sv
